//--- flist.f
+incdir+logic
logic/exec_isa_pkg.sv
logic/exec_bus_pkg.sv
logic/exec_alu.sv
logic/exec_branch_unit.sv
logic/exec_store_unit.sv
logic/exec_control.sv
logic/exec_stage.sv
bench/exec_clkgen.sv
bench/exec_sva.sv
bench/exec_tb.sv

//--- Makefile
# Verilator build for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exec_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/exec_tb.sv
/*
  Execute stage testbench
  Stimulus table with expected results, memory responder with random ack delay
  Value checks and watchdog
*/

`include "exec_params.svh"

module exec_tb;

  timeunit 1ns;
  timeprecision 1ps;

  typedef enum {K_WB, K_BR, K_NONE, K_ST} kind_e;

  typedef struct {
    string                   name;
    exec_isa_pkg::issue_t    iss;
    kind_e                   kind;
    logic [`EXEC_XLEN-1:0]   exp;
    logic                    taken;
    int                      n_xfer;
    exec_bus_pkg::dmem_req_t x0;
    exec_bus_pkg::dmem_req_t x1;
  } entry_t;

  logic                    clk;
  logic                    rst;
  logic                    issue_stb;
  exec_isa_pkg::issue_t    issue;
  logic                    busy;
  logic                    wb_stb;
  exec_bus_pkg::wb_t       wb;
  logic                    branch_stb;
  exec_bus_pkg::branch_t   branch;
  logic                    dmem_stb;
  exec_bus_pkg::dmem_req_t dmem_req;
  logic                    dmem_ack;

  entry_t                  tests_q[$];
  exec_bus_pkg::dmem_req_t xfers_q[$];
  int                      n_tests;
  int                      errors;

  exec_clkgen clkgen0 (.clk_o(clk), .rst_o(rst));

  exec_stage dut0 (
    .clk_i        (clk),
    .rst_i        (rst),
    .issue_stb_i  (issue_stb),
    .issue_i      (issue),
    .busy_o       (busy),
    .wb_stb_o     (wb_stb),
    .wb_o         (wb),
    .branch_stb_o (branch_stb),
    .branch_o     (branch),
    .dmem_stb_o   (dmem_stb),
    .dmem_req_o   (dmem_req),
    .dmem_ack_i   (dmem_ack)
  );

  bind exec_stage exec_sva sva0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .issue_stb_i  (issue_stb_i),
    .busy_i       (busy_o),
    .wb_stb_i     (wb_stb_o),
    .branch_stb_i (branch_stb_o),
    .dmem_stb_i   (dmem_stb_o),
    .dmem_req_i   (dmem_req_o),
    .dmem_ack_i   (dmem_ack_i)
  );

  task automatic check(string name, string what, logic [63:0] exp, logic [63:0] act);
    if (exp !== act)
    begin
      errors++;
      $display("ERROR %s %s: expected %h, actual %h", name, what, exp, act);
      $display("Regression failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic add_test(string name, exec_isa_pkg::op_e op, logic [31:0] a, logic [31:0] b,
                          logic [31:0] opnd, logic [31:0] pc, logic [9:0] off, kind_e kind,
                          logic [31:0] exp, logic taken);
    entry_t e;
    e.name   = name;
    e.iss    = '{op, a, b, opnd, pc, off, 4'(tests_q.size())};
    e.kind   = kind;
    e.exp    = exp;
    e.taken  = taken;
    e.n_xfer = 0;
    tests_q.push_back(e);
  endtask

  // Long stores put the low half at the next halfword
  task automatic add_store(string name, exec_isa_pkg::op_e op, logic [31:0] a, logic [31:0] b,
                           logic [31:0] opnd, int n, logic [31:0] addr, logic [15:0] d0,
                           logic [1:0] sel0, logic [15:0] d1);
    entry_t e;
    e.name   = name;
    e.iss    = '{op, a, b, opnd, 32'h0, 10'h0, 4'h0};
    e.kind   = K_ST;
    e.exp    = '0;
    e.taken  = 1'b0;
    e.n_xfer = n;
    e.x0     = '{addr, d0, sel0, 1'b1};
    e.x1     = '{addr + 32'd2, d1, 2'b11, 1'b1};
    tests_q.push_back(e);
  endtask

  task automatic build_table();
    add_test("beq_reset", exec_isa_pkg::OP_BEQ, 0, 0, 0, 32'h100, 10'd4, K_BR, 0, 1'b0);
    add_test("bne_reset", exec_isa_pkg::OP_BNE, 0, 0, 0, 32'h100, 10'd4, K_BR, 32'h10a, 1'b1);
    add_test("add", exec_isa_pkg::OP_ADD, 5, 7, 0, 0, 0, K_WB, 32'd12, 0);
    add_test("sub", exec_isa_pkg::OP_SUB, 3, 5, 0, 0, 0, K_WB, 32'hfffffffe, 0);
    add_test("xor", exec_isa_pkg::OP_XOR, 32'hff00ff00, 32'h0ff00ff0, 0, 0, 0, K_WB,
             32'hf0f0f0f0, 0);
    add_test("ashr", exec_isa_pkg::OP_ASHR, 32'h80000010, 32'h24, 0, 0, 0, K_WB,
             32'hf8000001, 0);
    add_test("lshr", exec_isa_pkg::OP_LSHR, 32'h80000010, 32'h24, 0, 0, 0, K_WB,
             32'h08000001, 0);
    add_test("ashl", exec_isa_pkg::OP_ASHL, 32'h1, 32'h21, 0, 0, 0, K_WB, 32'h2, 0);
    add_test("sex_b", exec_isa_pkg::OP_SEX_B, 0, 32'h12345680, 0, 0, 0, K_WB, 32'hffffff80, 0);
    add_test("zex_s", exec_isa_pkg::OP_ZEX_S, 0, 32'hdeadbeef, 0, 0, 0, K_WB, 32'h0000beef, 0);
    add_test("inc", exec_isa_pkg::OP_INC, 32'h10, 0, 0, 0, 10'h3ff, K_WB, 32'h10f, 0);
    add_test("dec", exec_isa_pkg::OP_DEC, 32'h10, 0, 0, 0, 10'h005, K_WB, 32'hb, 0);
    add_test("mul", exec_isa_pkg::OP_MUL, 6, 7, 0, 0, 0, K_WB, 32'd42, 0);
    add_test("ldi", exec_isa_pkg::OP_LDI, 0, 0, 32'h12345678, 0, 0, K_WB, 32'h12345678, 0);
    add_test("neg", exec_isa_pkg::OP_NEG, 0, 1, 0, 0, 0, K_WB, 32'hffffffff, 0);
    // -1 against 1 is signed less and unsigned greater
    add_test("cmp_m1_1", exec_isa_pkg::OP_CMP, 32'hffffffff, 1, 0, 0, 0, K_NONE, 0, 0);
    add_test("blt", exec_isa_pkg::OP_BLT, 0, 0, 0, 32'h200, 10'h3fe, K_BR, 32'h1fe, 1'b1);
    add_test("bgtu", exec_isa_pkg::OP_BGTU, 0, 0, 0, 32'h200, 10'h010, K_BR, 32'h222, 1'b1);
    add_test("bge", exec_isa_pkg::OP_BGE, 0, 0, 0, 32'h200, 10'h0, K_BR, 0, 1'b0);
    add_test("bltu", exec_isa_pkg::OP_BLTU, 0, 0, 0, 32'h200, 10'h0, K_BR, 0, 1'b0);
    add_test("ble", exec_isa_pkg::OP_BLE, 0, 0, 0, 32'h200, 10'h0, K_BR, 32'h202, 1'b1);
    add_test("bgeu", exec_isa_pkg::OP_BGEU, 0, 0, 0, 32'h200, 10'h200, K_BR, 32'hfffffe02, 1'b1);
    add_test("bgt", exec_isa_pkg::OP_BGT, 0, 0, 0, 32'h200, 10'h0, K_BR, 0, 1'b0);
    add_test("bleu", exec_isa_pkg::OP_BLEU, 0, 0, 0, 32'h200, 10'h0, K_BR, 0, 1'b0);
    add_test("cmp_eq", exec_isa_pkg::OP_CMP, 5, 5, 0, 0, 0, K_NONE, 0, 0);
    add_test("beq", exec_isa_pkg::OP_BEQ, 0, 0, 0, 32'h300, 10'd1, K_BR, 32'h304, 1'b1);
    add_test("bne_eq", exec_isa_pkg::OP_BNE, 0, 0, 0, 32'h300, 10'd1, K_BR, 0, 1'b0);
    add_test("jmp", exec_isa_pkg::OP_JMP, 32'h40000000, 0, 0, 0, 0, K_BR, 32'h40000000, 1'b1);
    add_test("jmpa", exec_isa_pkg::OP_JMPA, 0, 0, 32'h80000020, 0, 0, K_BR, 32'h80000020, 1'b1);
    add_store("st_b", exec_isa_pkg::OP_ST_B, 32'h1000, 32'h123456ab, 0, 1, 32'h1000,
              16'h00ab, 2'b01, 0);
    add_store("st_s", exec_isa_pkg::OP_ST_S, 32'h1100, 32'h9876fedc, 0, 1, 32'h1100,
              16'hfedc, 2'b11, 0);
    add_store("sto_b", exec_isa_pkg::OP_STO_B, 32'h1000, 32'hffffffc3, 32'h31, 1, 32'h1031,
              16'h00c3, 2'b01, 0);
    add_store("sto_s", exec_isa_pkg::OP_STO_S, 32'h1000, 32'hcafebabe, 32'h20, 1, 32'h1020,
              16'hbabe, 2'b11, 0);
    add_store("sta_b", exec_isa_pkg::OP_STA_B, 32'h7f, 0, 32'h3001, 1, 32'h3001,
              16'h007f, 2'b01, 0);
    add_store("sta_s", exec_isa_pkg::OP_STA_S, 32'h13572468, 32'hffffffff, 32'h3100, 1,
              32'h3100, 16'h2468, 2'b11, 0);
    add_store("st_l", exec_isa_pkg::OP_ST_L, 32'h2000, 32'h11223344, 0, 2, 32'h2000,
              16'h1122, 2'b11, 16'h3344);
    add_store("sto_l", exec_isa_pkg::OP_STO_L, 32'h2000, 32'ha5a55a5a, 32'h4, 2, 32'h2004,
              16'ha5a5, 2'b11, 16'h5a5a);
    add_store("sta_l", exec_isa_pkg::OP_STA_L, 32'hdeadbeef, 0, 32'h5000, 2, 32'h5000,
              16'hdead, 2'b11, 16'hbeef);
  endtask

  // Memory responder acking 1 to 4 cycles after each request
  initial
  begin
    int delay;
    void'($urandom(32'h097b5cd1));
    forever
    begin
      @(posedge clk);
      if (dmem_stb === 1'b1)
      begin
        xfers_q.push_back(dmem_req);
        delay = 1 + ($urandom % 4);
        repeat (delay - 1) @(posedge clk);
        dmem_ack <= 1'b1;
        @(posedge clk);
        dmem_ack <= 1'b0;
      end
    end
  end

  initial
  begin
    wait (n_tests > 0);
    #(n_tests * 12 * 20);
    $display("Timeout: the DUT stopped responding before all tests finished");
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    entry_t t;
    issue_stb = 1'b0;
    issue     = '0;
    dmem_ack  = 1'b0;
    errors    = 0;
    n_tests   = 0;
    build_table();
    n_tests = tests_q.size();
    wait (rst === 1'b0);
    @(negedge clk);
    check("reset", "busy", 0, busy);
    check("reset", "strobes", 0, {wb_stb, branch_stb, dmem_stb});
    foreach (tests_q[i])
    begin
      t = tests_q[i];
      xfers_q.delete();
      @(posedge clk);
      issue_stb <= 1'b1;
      issue     <= t.iss;
      @(posedge clk);
      issue_stb <= 1'b0;
      @(negedge clk);
      case (t.kind)
        K_WB:
        begin
          check(t.name, "wb_stb", 1, wb_stb);
          check(t.name, "wb index", t.iss.dest, wb.index);
          check(t.name, "wb data", t.exp, wb.data);
        end
        K_BR:
        begin
          check(t.name, "branch_stb", t.taken, branch_stb);
          if (t.taken)
            check(t.name, "target", t.exp, branch.target);
        end
        K_NONE:
          check(t.name, "strobes", 0, {wb_stb, branch_stb, dmem_stb, busy});
        K_ST:
        begin
          check(t.name, "dmem_stb", 1, dmem_stb);
          check(t.name, "busy", 1, busy);
          while (busy)
            @(negedge clk);
          check(t.name, "transfers", t.n_xfer, xfers_q.size());
          check(t.name, "first", t.x0, xfers_q[0]);
          if (t.n_xfer == 2)
            check(t.name, "second", t.x1, xfers_q[1]);
        end
        default: ;
      endcase
    end
    repeat (2) @(negedge clk);
    if (errors == 0)
    begin
      $display("Regression passed");
      $finish;
    end
    else
    begin
      $display("Regression failed");
      $fatal(1, "checks failed");
    end
  end

endmodule

//--- bench/exec_sva.sv
/*
  Bound assertions for the execute stage
  Issue handshake, request/ack pairing, request stability, output strobes
*/

module exec_sva (
  input logic                    clk_i,
  input logic                    rst_i,
  input logic                    issue_stb_i,
  input logic                    busy_i,
  input logic                    wb_stb_i,
  input logic                    branch_stb_i,
  input logic                    dmem_stb_i,
  input exec_bus_pkg::dmem_req_t dmem_req_i,
  input logic                    dmem_ack_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic pending_q;

  // Request outstanding until its ack
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      pending_q <= 1'b0;
    else if (dmem_stb_i)
      pending_q <= 1'b1;
    else if (dmem_ack_i)
      pending_q <= 1'b0;
  end

  a_no_issue_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    busy_i |-> !issue_stb_i)
    else $error("issue strobe while busy");

  a_req_after_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    dmem_stb_i |-> !pending_q)
    else $error("new request before ack");

  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    ((dmem_stb_i || pending_q) && !dmem_ack_i) |=> $stable(dmem_req_i))
    else $error("request payload changed while waiting");

  a_one_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({wb_stb_i, branch_stb_i, dmem_stb_i}))
    else $error("more than one output strobe");

endmodule

//--- bench/exec_clkgen.sv
/*
  Testbench clock and reset
  20 ns clock, reset high for two cycles
*/

module exec_clkgen (
  output logic clk_o,
  output logic rst_o
);

  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- logic/exec_stage.sv
/*
  Execute stage top level
  Control with arithmetic, branch and store datapaths
*/

module exec_stage (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    issue_stb_i,
  input  exec_isa_pkg::issue_t    issue_i,
  output logic                    busy_o,
  output logic                    wb_stb_o,
  output exec_bus_pkg::wb_t       wb_o,
  output logic                    branch_stb_o,
  output exec_bus_pkg::branch_t   branch_o,
  output logic                    dmem_stb_o,
  output exec_bus_pkg::dmem_req_t dmem_req_o,
  input  logic                    dmem_ack_i
);

  logic                      alu_go;
  logic                      cmp_go;
  logic                      br_go;
  logic                      st_go;
  exec_bus_pkg::store_half_e half;

  exec_control u_control (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .issue_stb_i (issue_stb_i),
    .op_i        (issue_i.op),
    .dmem_ack_i  (dmem_ack_i),
    .alu_go_o    (alu_go),
    .cmp_go_o    (cmp_go),
    .br_go_o     (br_go),
    .st_go_o     (st_go),
    .half_o      (half),
    .dmem_stb_o  (dmem_stb_o),
    .busy_o      (busy_o)
  );

  exec_alu u_alu (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .go_i     (alu_go),
    .issue_i  (issue_i),
    .wb_stb_o (wb_stb_o),
    .wb_o     (wb_o)
  );

  exec_branch_unit u_branch (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cmp_go_i     (cmp_go),
    .br_go_i      (br_go),
    .issue_i      (issue_i),
    .branch_stb_o (branch_stb_o),
    .branch_o     (branch_o)
  );

  exec_store_unit u_store (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .go_i       (st_go),
    .half_i     (half),
    .issue_i    (issue_i),
    .dmem_req_o (dmem_req_o)
  );

endmodule

//--- logic/exec_control.sv
/*
  Execute stage control
  Instruction class decode and go strobes for the three datapaths
  Store transfer FSM against the memory acknowledge, request strobe and busy
*/

module exec_control (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      issue_stb_i,
  input  exec_isa_pkg::op_e         op_i,
  input  logic                      dmem_ack_i,
  output logic                      alu_go_o,
  output logic                      cmp_go_o,
  output logic                      br_go_o,
  output logic                      st_go_o,
  output exec_bus_pkg::store_half_e half_o,
  output logic                      dmem_stb_o,
  output logic                      busy_o
);

  exec_bus_pkg::ctrl_state_e state_q;
  logic                      long_q;
  logic                      is_alu;
  logic                      is_cmp;
  logic                      is_br;
  logic                      is_st;
  logic                      is_long;

  always_comb
  begin
    is_alu  = 1'b0;
    is_cmp  = 1'b0;
    is_br   = 1'b0;
    is_st   = 1'b0;
    is_long = 1'b0;
    case (op_i)
      exec_isa_pkg::OP_ADD,   exec_isa_pkg::OP_SUB,   exec_isa_pkg::OP_AND,
      exec_isa_pkg::OP_OR,    exec_isa_pkg::OP_XOR,   exec_isa_pkg::OP_NOT,
      exec_isa_pkg::OP_NEG,   exec_isa_pkg::OP_MOV,   exec_isa_pkg::OP_ASHL,
      exec_isa_pkg::OP_ASHR,  exec_isa_pkg::OP_LSHR,  exec_isa_pkg::OP_MUL,
      exec_isa_pkg::OP_INC,   exec_isa_pkg::OP_DEC,   exec_isa_pkg::OP_LDI,
      exec_isa_pkg::OP_SEX_B, exec_isa_pkg::OP_SEX_S, exec_isa_pkg::OP_ZEX_B,
      exec_isa_pkg::OP_ZEX_S:
        is_alu = 1'b1;
      exec_isa_pkg::OP_CMP:
        is_cmp = 1'b1;
      exec_isa_pkg::OP_BEQ,   exec_isa_pkg::OP_BNE,   exec_isa_pkg::OP_BLT,
      exec_isa_pkg::OP_BGT,   exec_isa_pkg::OP_BLTU,  exec_isa_pkg::OP_BGTU,
      exec_isa_pkg::OP_BLE,   exec_isa_pkg::OP_BGE,   exec_isa_pkg::OP_BLEU,
      exec_isa_pkg::OP_BGEU,  exec_isa_pkg::OP_JMP,   exec_isa_pkg::OP_JMPA:
        is_br = 1'b1;
      exec_isa_pkg::OP_ST_B,  exec_isa_pkg::OP_ST_S,  exec_isa_pkg::OP_STO_B,
      exec_isa_pkg::OP_STO_S, exec_isa_pkg::OP_STA_B, exec_isa_pkg::OP_STA_S:
        is_st = 1'b1;
      exec_isa_pkg::OP_ST_L,  exec_isa_pkg::OP_STO_L, exec_isa_pkg::OP_STA_L:
      begin
        is_st   = 1'b1;
        is_long = 1'b1;
      end
      default: ;
    endcase
  end

  assign alu_go_o = issue_stb_i & is_alu;
  assign cmp_go_o = issue_stb_i & is_cmp;
  assign br_go_o  = issue_stb_i & is_br;
  assign st_go_o  = issue_stb_i & is_st;

  // Second half is on the bus only while waiting for its ack
  assign half_o = (state_q == exec_bus_pkg::WAIT_SECOND) ? exec_bus_pkg::SECOND
                                                         : exec_bus_pkg::FIRST;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q    <= exec_bus_pkg::IDLE;
      long_q     <= 1'b0;
      dmem_stb_o <= 1'b0;
      busy_o     <= 1'b0;
    end
    else
    begin
      dmem_stb_o <= 1'b0;
      case (state_q)
        exec_bus_pkg::IDLE:
          if (st_go_o)
          begin
            state_q    <= exec_bus_pkg::WAIT_FIRST;
            long_q     <= is_long;
            dmem_stb_o <= 1'b1;
            busy_o     <= 1'b1;
          end
        exec_bus_pkg::WAIT_FIRST:
          if (dmem_ack_i)
          begin
            if (long_q)
            begin
              state_q    <= exec_bus_pkg::WAIT_SECOND;
              dmem_stb_o <= 1'b1;
            end
            else
            begin
              state_q <= exec_bus_pkg::IDLE;
              busy_o  <= 1'b0;
            end
          end
        exec_bus_pkg::WAIT_SECOND:
          if (dmem_ack_i)
          begin
            state_q <= exec_bus_pkg::IDLE;
            busy_o  <= 1'b0;
          end
        default:
        begin
          state_q <= exec_bus_pkg::IDLE;
          busy_o  <= 1'b0;
        end
      endcase
    end
  end

endmodule

//--- logic/exec_store_unit.sv
/*
  Store datapath
  Address mode and size decode, lane select and data formatting
  First request register and the second-half holding register of a long store
*/

`include "exec_params.svh"

module exec_store_unit (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      go_i,
  input  exec_bus_pkg::store_half_e half_i,
  input  exec_isa_pkg::issue_t      issue_i,
  output exec_bus_pkg::dmem_req_t   dmem_req_o
);

  exec_bus_pkg::dmem_req_t first_q;
  exec_bus_pkg::dmem_req_t second_q;
  logic [`EXEC_XLEN-1:0]   addr;
  logic [`EXEC_XLEN-1:0]   sdata;
  logic                    is_byte;
  logic                    is_long;

  always_comb
  begin
    addr    = issue_i.reg_a;
    sdata   = issue_i.reg_b;
    is_byte = 1'b0;
    is_long = 1'b0;
    case (issue_i.op)
      exec_isa_pkg::OP_ST_B:  is_byte = 1'b1;
      exec_isa_pkg::OP_ST_L:  is_long = 1'b1;
      exec_isa_pkg::OP_STO_B,
      exec_isa_pkg::OP_STO_S,
      exec_isa_pkg::OP_STO_L:
      begin
        addr    = issue_i.operand + issue_i.reg_a;
        is_byte = issue_i.op == exec_isa_pkg::OP_STO_B;
        is_long = issue_i.op == exec_isa_pkg::OP_STO_L;
      end
      // Absolute mode stores reg_a
      exec_isa_pkg::OP_STA_B,
      exec_isa_pkg::OP_STA_S,
      exec_isa_pkg::OP_STA_L:
      begin
        addr    = issue_i.operand;
        sdata   = issue_i.reg_a;
        is_byte = issue_i.op == exec_isa_pkg::OP_STA_B;
        is_long = issue_i.op == exec_isa_pkg::OP_STA_L;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      first_q  <= '0;
      second_q <= '0;
    end
    else if (go_i)
    begin
      first_q.addr  <= addr;
      first_q.we    <= 1'b1;
      first_q.sel   <= is_byte ? 2'b01 : 2'b11;
      if (is_byte)
        first_q.data <= {{(`EXEC_BUS_W-8){1'b0}}, sdata[7:0]};
      else if (is_long)
        first_q.data <= sdata[`EXEC_XLEN-1:`EXEC_BUS_W];
      else
        first_q.data <= sdata[`EXEC_BUS_W-1:0];
      // Low half of a long goes to the next halfword
      second_q.addr <= addr + `EXEC_XLEN'(2);
      second_q.data <= sdata[`EXEC_BUS_W-1:0];
      second_q.sel  <= 2'b11;
      second_q.we   <= 1'b1;
    end
  end

  assign dmem_req_o = (half_i == exec_bus_pkg::SECOND) ? second_q : first_q;

endmodule

//--- logic/exec_branch_unit.sv
/*
  Compare and branch datapath
  Condition flag register written by cmp
  Branch condition, pc-relative and absolute targets, branch output register
*/

`include "exec_params.svh"

module exec_branch_unit (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  cmp_go_i,
  input  logic                  br_go_i,
  input  exec_isa_pkg::issue_t  issue_i,
  output logic                  branch_stb_o,
  output exec_bus_pkg::branch_t branch_o
);

  exec_isa_pkg::cc_t     cc_q;
  exec_isa_pkg::cc_t     cc_new;
  logic                  taken;
  logic [`EXEC_XLEN-1:0] pcrel_target;
  logic [`EXEC_XLEN-1:0] target;

  assign cc_new.eq  = issue_i.reg_a == issue_i.reg_b;
  assign cc_new.lt  = $signed(issue_i.reg_a) < $signed(issue_i.reg_b);
  assign cc_new.gt  = $signed(issue_i.reg_a) > $signed(issue_i.reg_b);
  assign cc_new.ltu = issue_i.reg_a < issue_i.reg_b;
  assign cc_new.gtu = issue_i.reg_a > issue_i.reg_b;

  // Offset counts 16-bit words from the next instruction
  assign pcrel_target = issue_i.pc + `EXEC_XLEN'(2)
                      + {{(`EXEC_XLEN-`EXEC_OFFS_W-1){issue_i.offset[`EXEC_OFFS_W-1]}},
                         issue_i.offset, 1'b0};

  always_comb
  begin
    target = pcrel_target;
    case (issue_i.op)
      exec_isa_pkg::OP_BEQ:  taken = cc_q.eq;
      exec_isa_pkg::OP_BNE:  taken = !cc_q.eq;
      exec_isa_pkg::OP_BLT:  taken = cc_q.lt;
      exec_isa_pkg::OP_BGT:  taken = cc_q.gt;
      exec_isa_pkg::OP_BLTU: taken = cc_q.ltu;
      exec_isa_pkg::OP_BGTU: taken = cc_q.gtu;
      exec_isa_pkg::OP_BLE:  taken = cc_q.eq | cc_q.lt;
      exec_isa_pkg::OP_BGE:  taken = cc_q.eq | cc_q.gt;
      exec_isa_pkg::OP_BLEU: taken = cc_q.eq | cc_q.ltu;
      exec_isa_pkg::OP_BGEU: taken = cc_q.eq | cc_q.gtu;
      exec_isa_pkg::OP_JMP:
      begin
        taken  = 1'b1;
        target = issue_i.reg_a;
      end
      exec_isa_pkg::OP_JMPA:
      begin
        taken  = 1'b1;
        target = issue_i.operand;
      end
      default: taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      cc_q         <= '0;
      branch_stb_o <= 1'b0;
    end
    else
    begin
      if (cmp_go_i)
        cc_q <= cc_new;
      branch_stb_o <= br_go_i & taken;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (br_go_i)
      branch_o.target <= target;
  end

endmodule

//--- logic/exec_alu.sv
/*
  Register arithmetic datapath
  Logic, add/sub, shifts, multiply, extensions, inc/dec and ldi
  Write-back strobe and payload register
*/

`include "exec_params.svh"

module exec_alu (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 go_i,
  input  exec_isa_pkg::issue_t issue_i,
  output logic                 wb_stb_o,
  output exec_bus_pkg::wb_t    wb_o
);

  logic [`EXEC_XLEN-1:0] a;
  logic [`EXEC_XLEN-1:0] b;
  logic [`EXEC_XLEN-1:0] incdec;
  logic [4:0]            shamt;
  logic [`EXEC_XLEN-1:0] result;

  assign a      = issue_i.reg_a;
  assign b      = issue_i.reg_b;
  assign shamt  = issue_i.reg_b[4:0];
  // Inc/dec amount lives in the low offset bits
  assign incdec = {{(`EXEC_XLEN-8){1'b0}}, issue_i.offset[7:0]};

  always_comb
  begin
    case (issue_i.op)
      exec_isa_pkg::OP_ADD:   result = a + b;
      exec_isa_pkg::OP_SUB:   result = a - b;
      exec_isa_pkg::OP_AND:   result = a & b;
      exec_isa_pkg::OP_OR:    result = a | b;
      exec_isa_pkg::OP_XOR:   result = a ^ b;
      exec_isa_pkg::OP_NOT:   result = ~b;
      exec_isa_pkg::OP_NEG:   result = -b;
      exec_isa_pkg::OP_MOV:   result = b;
      exec_isa_pkg::OP_ASHL:  result = a << shamt;
      exec_isa_pkg::OP_ASHR:  result = $signed(a) >>> shamt;
      exec_isa_pkg::OP_LSHR:  result = a >> shamt;
      exec_isa_pkg::OP_MUL:   result = a * b;
      exec_isa_pkg::OP_INC:   result = a + incdec;
      exec_isa_pkg::OP_DEC:   result = a - incdec;
      exec_isa_pkg::OP_LDI:   result = issue_i.operand;
      exec_isa_pkg::OP_SEX_B: result = {{(`EXEC_XLEN-8){b[7]}}, b[7:0]};
      exec_isa_pkg::OP_SEX_S: result = {{(`EXEC_XLEN-16){b[15]}}, b[15:0]};
      exec_isa_pkg::OP_ZEX_B: result = {{(`EXEC_XLEN-8){1'b0}}, b[7:0]};
      exec_isa_pkg::OP_ZEX_S: result = {{(`EXEC_XLEN-16){1'b0}}, b[15:0]};
      default:                result = '0;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      wb_stb_o <= 1'b0;
    else
      wb_stb_o <= go_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (go_i)
    begin
      wb_o.index <= issue_i.dest;
      wb_o.data  <= result;
    end
  end

endmodule

//--- logic/exec_bus_pkg.sv
/*
  Output side types of the execute stage
  Memory request, write-back and branch payloads
  Store half select and store sequencing states
*/

`include "exec_params.svh"

package exec_bus_pkg;

  typedef struct packed {
    logic [`EXEC_XLEN-1:0]  addr;
    logic [`EXEC_BUS_W-1:0] data;
    logic [1:0]             sel;
    logic                   we;
  } dmem_req_t;

  typedef struct packed {
    logic [`EXEC_IDX_W-1:0] index;
    logic [`EXEC_XLEN-1:0]  data;
  } wb_t;

  typedef struct packed {
    logic [`EXEC_XLEN-1:0] target;
  } branch_t;

  typedef enum logic {
    FIRST  = 1'b0,
    SECOND = 1'b1
  } store_half_e;

  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    WAIT_FIRST  = 2'd1,
    WAIT_SECOND = 2'd2
  } ctrl_state_e;

endpackage

//--- logic/exec_isa_pkg.sv
/*
  Instruction set types for the execute stage
  Opcode enum, condition flag struct, issued instruction struct
*/

`include "exec_params.svh"

package exec_isa_pkg;

  // Branch and inc/dec codes sit above 0x40
  typedef enum logic [6:0] {
    OP_LDI   = 7'h01, OP_MOV   = 7'h02, OP_ADD   = 7'h05, OP_STA_L = 7'h09,
    OP_ST_L  = 7'h0b, OP_STO_L = 7'h0d, OP_CMP   = 7'h0e, OP_SEX_B = 7'h10,
    OP_SEX_S = 7'h11, OP_ZEX_B = 7'h12, OP_ZEX_S = 7'h13, OP_JMPA  = 7'h1a,
    OP_ST_B  = 7'h1e, OP_STA_B = 7'h1f, OP_ST_S  = 7'h23, OP_STA_S = 7'h24,
    OP_JMP   = 7'h25, OP_AND   = 7'h26, OP_LSHR  = 7'h27, OP_ASHL  = 7'h28,
    OP_SUB   = 7'h29, OP_NEG   = 7'h2a, OP_OR    = 7'h2b, OP_NOT   = 7'h2c,
    OP_ASHR  = 7'h2d, OP_XOR   = 7'h2e, OP_MUL   = 7'h2f, OP_STO_B = 7'h37,
    OP_STO_S = 7'h39,
    OP_BEQ   = 7'h40, OP_BNE   = 7'h41, OP_BLT   = 7'h42, OP_BGT   = 7'h43,
    OP_BLTU  = 7'h44, OP_BGTU  = 7'h45, OP_BGE   = 7'h46, OP_BLE   = 7'h47,
    OP_BGEU  = 7'h48, OP_BLEU  = 7'h49,
    OP_INC   = 7'h50, OP_DEC   = 7'h51
  } op_e;

  // lt and gt are signed, ltu and gtu unsigned
  typedef struct packed {
    logic eq;
    logic lt;
    logic gt;
    logic ltu;
    logic gtu;
  } cc_t;

  typedef struct packed {
    op_e                     op;
    logic [`EXEC_XLEN-1:0]   reg_a;
    logic [`EXEC_XLEN-1:0]   reg_b;
    logic [`EXEC_XLEN-1:0]   operand;
    logic [`EXEC_XLEN-1:0]   pc;
    logic [`EXEC_OFFS_W-1:0] offset;
    logic [`EXEC_IDX_W-1:0]  dest;
  } issue_t;

endpackage

//--- logic/exec_params.svh
/*
  Width macros for the execute stage
  Data path, memory bus, register index and branch offset widths
*/

`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Data path width
`define EXEC_XLEN 32

// Memory data bus width
`define EXEC_BUS_W 16

// Register file index width
`define EXEC_IDX_W 4

// Pc-relative branch offset field
`define EXEC_OFFS_W 10

`endif
